//--- flist.f
+incdir+source
+incdir+testbench
source/arp_pkg.sv
source/arp_cfg_regs.sv
source/arp_byte_counter.sv
source/arp_ctrl_fsm.sv
source/arp_rx_parse.sv
source/arp_tx_build.sv
source/arp_responder.sv
testbench/arp_responder_tb.sv

//--- testbench/arp_tb_cases.svh
`ifndef ARP_TB_CASES_SVH
`define ARP_TB_CASES_SVH

// each row holds oper, tpa, sha, spa, total length, err beat, back-pressure and reply expected
// tpa and spa are IPv4 words, the device answers to dev_ipv4

localparam int num_cases = 16;

tb_case_t cases [num_cases];

task load_cases();
  cases[0]  = {16'd1, dev_ipv4, 48'h0a1b_2c3d_4e5f, 32'h0a00_0001, 6'd28, no_err, 1'b0, 1'b1};
  cases[1]  = {16'd1, 32'h0a00_0008, 48'h0a1b_2c3d_4e5f, 32'h0a00_0001, 6'd28, no_err,
               1'b0, 1'b0}; // someone else's address
  cases[2]  = {16'd2, dev_ipv4, 48'h0a1b_2c3d_4e5f, 32'h0a00_0001, 6'd28, no_err, 1'b0, 1'b0};
  cases[3]  = {16'd1, dev_ipv4, 48'h0a1b_2c3d_4e5f, 32'h0a00_0001, 6'd20, no_err, 1'b0, 1'b0};
  cases[4]  = {16'd1, dev_ipv4, 48'h0a1b_2c3d_4e5f, 32'h0a00_0001, 6'd50, no_err, 1'b0, 1'b0};
  cases[5]  = {16'd1, dev_ipv4, 48'h0a1b_2c3d_4e5f, 32'h0a00_0001, 6'd28, 6'd10, 1'b0, 1'b0};
  cases[6]  = {16'd1, dev_ipv4, 48'hc0ff_ee00_0101, 32'hc0a8_0105, 6'd46, no_err, 1'b0, 1'b1};
  cases[7]  = {16'd1, dev_ipv4, 48'h00e0_4c68_0001, 32'h0a00_0002, 6'd29, no_err, 1'b0, 1'b1};
  cases[8]  = {16'd1, dev_ipv4, 48'h3c22_fb10_9a7e, 32'h0a00_00fe, 6'd28, no_err, 1'b1, 1'b1};
  cases[9]  = {16'd1, dev_ipv4, 48'hfeed_face_cafe, 32'hac10_2003, 6'd40, no_err, 1'b1, 1'b1};
  cases[10] = {16'd1, dev_ipv4, 48'h0a1b_2c3d_4e5f, 32'h0a00_0001, 6'd46, 6'd40, 1'b0, 1'b0};
  cases[11] = {16'd1, dev_ipv4, 48'h0a1b_2c3d_4e5f, 32'h0a00_0001, 6'd48, no_err, 1'b0, 1'b0};
  cases[12] = {16'd1, dev_ipv4, 48'h5254_0012_3456, 32'h0a00_0063, 6'd33, no_err, 1'b1, 1'b1};
  cases[13] = {16'd1, dev_ipv4, 48'h0a1b_2c3d_4e5f, 32'h0a00_0001, 6'd28, 6'd27, 1'b0, 1'b0};
  cases[14] = {16'd1, dev_ipv4, 48'h0a1b_2c3d_4e5f, 32'h0a00_0001, 6'd27, no_err, 1'b0, 1'b0};
  cases[15] = {16'd1, dev_ipv4, 48'h8086_0000_7710, 32'h0a00_0010, 6'd30, no_err, 1'b0, 1'b1};
endtask

`endif

//--- testbench/arp_responder_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "arp_config.svh"

module arp_responder_tb;

  typedef struct packed {
    logic [15:0] oper;
    logic [31:0] tpa;
    logic [47:0] sha;
    logic [31:0] spa;
    logic [5:0]  len;
    logic [5:0]  err_at; // beat index carrying err, no_err for a clean frame
    logic        bp;     // random tx_ready while the reply streams
    logic        rep;    // a reply is expected
  } tb_case_t;

  localparam logic [47:0] dev_mac  = 48'h0211_2233_4455;
  localparam logic [31:0] dev_ipv4 = 32'h0a00_0007;
  localparam logic [5:0]  no_err   = 6'd63;

  logic                  clk;
  logic                  fsm_rst;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [7:0]            paddr;
  logic [31:0]           pwdata;
  logic [31:0]           prdata;
  logic                  pready;
  logic                  pslverr;
  arp_pkg::arp_rx_beat_t rx;
  arp_pkg::arp_tx_beat_t tx;
  logic                  tx_ready;

  `include "arp_tb_cases.svh"

  arp_responder arp_responder_i (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .rx       (rx),
    .tx       (tx),
    .tx_ready (tx_ready)
  );

  always #20 clk = ~clk;

  task check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("[ERROR] %s expected %h got %h", name, exp, act);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  task report_timeout(input string what);
    $display("timeout after 500 cycles waiting for %s", what);
    $display("Test failures found");
    $fatal(1);
  endtask

  // one access, setup then access phase
  task apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                  output logic [31:0] rd, output logic err);
    int waits;
    @(posedge clk);
    #2;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk);
    #2;
    penable = 1'b1;
    waits   = 0;
    while (!pready) begin
      @(posedge clk);
      #2;
      waits++;
      if (waits > 500) report_timeout("pready");
    end
    check_val("pready", 1, pready);
    rd  = prdata;
    err = pslverr;
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task write_reg(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
    logic [31:0] rd;
    logic        err;
    apb_access(1'b1, addr, data, rd, err);
    check_val("pslverr", exp_err, err);
  endtask

  task read_reg(input logic [7:0] addr, output logic [31:0] rd, output logic err);
    apb_access(1'b0, addr, 32'h0, rd, err);
  endtask

  function logic [223:0] request_word(input tb_case_t c);
    request_word = {`ARP_HTYPE_ETH, `ARP_PTYPE_IPV4, `ARP_HLEN_ETH, `ARP_PLEN_IPV4,
                    c.oper, c.sha, c.spa, 48'h0, c.tpa};
  endfunction

  // answer carries the device as sender and the asker as target
  function logic [223:0] reply_word(input tb_case_t c);
    reply_word = {`ARP_HTYPE_ETH, `ARP_PTYPE_IPV4, `ARP_HLEN_ETH, `ARP_PLEN_IPV4,
                  `ARP_OPER_REP, dev_mac, dev_ipv4, c.sha, c.spa};
  endfunction

  task send_frame(input tb_case_t c);
    logic [223:0] req;
    logic [7:0]   b;
    int           i;
    req = request_word(c);
    for (i = 0; i < c.len; i++) begin
      b = 8'h00; // padding
      if (i < `ARP_HDR_LEN) b = req[223 - 8*i -: 8];
      @(posedge clk);
      #2;
      rx = {b, 1'b1, i == c.len - 1, i == c.err_at, 1'b1}; // dat val last err is_arp
    end
    @(posedge clk);
    #2;
    rx = '0;
  endtask

  task collect_reply(input tb_case_t c);
    logic [223:0] exp;
    logic [31:0]  rnd;
    logic [7:0]   held;
    logic         stalled;
    logic         seen;
    int           got;
    int           cycles;
    exp     = reply_word(c);
    got     = 0;
    cycles  = 0;
    stalled = 1'b0;
    seen    = 1'b0;
    while (got < `ARP_HDR_LEN) begin
      @(posedge clk);
      #2;
      cycles++;
      if (cycles > 500) report_timeout("reply transfers");
      rnd      = $urandom;
      tx_ready = c.bp ? rnd[0] : 1'b1;
      if (stalled) begin
        check_val("tx.val", 1, tx.val);
        check_val("tx.dat", held, tx.dat);
      end
      if (tx.val && !seen) check_val("first_valid_cycle", 1, cycles);
      seen = seen | tx.val;
      if (tx.val && tx_ready) begin
        check_val($sformatf("tx.dat[%0d]", got), exp[223 - 8*got -: 8], tx.dat);
        check_val("tx.last", got == `ARP_HDR_LEN - 1, tx.last);
        got++;
      end
      stalled = tx.val && !tx_ready;
      held    = tx.dat;
    end
    if (!c.bp) check_val("reply_cycles", `ARP_HDR_LEN, cycles);
    @(posedge clk);
    #2;
    check_val("tx.val", 0, tx.val);
  endtask

  task expect_silence();
    repeat (8) begin
      @(posedge clk);
      #2;
      check_val("tx.val", 0, tx.val);
    end
  endtask

  initial begin
    int unsigned seed;
    logic [31:0] rd;
    logic        err;
    int          n_rep;
    int          n_drop;
    int          i;
    seed = 32'h7a79_6b0b;
    void'($urandom(seed));
    clk      = 1'b0;
    fsm_rst  = 1'b1;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    rx       = '0;
    tx_ready = 1'b1;
    n_rep    = 0;
    n_drop   = 0;
    repeat (16) @(posedge clk);
    #2;
    fsm_rst = 1'b0;

    write_reg(`REG_MAC_HI, {16'h0, dev_mac[47:32]}, 1'b0);
    write_reg(`REG_MAC_LO, dev_mac[31:0], 1'b0);
    write_reg(`REG_IPV4, dev_ipv4, 1'b0);
    write_reg(`REG_CTRL, 32'h1, 1'b0);
    read_reg(`REG_IPV4, rd, err);
    check_val("prdata ipv4", dev_ipv4, rd);

    load_cases();
    for (i = 0; i < num_cases; i++) begin
      send_frame(cases[i]);
      if (cases[i].rep) begin
        collect_reply(cases[i]);
        n_rep++;
      end else begin
        expect_silence();
        n_drop++;
      end
    end

    read_reg(`REG_RX_REQ, rd, err);
    check_val("rx_req count", n_rep, rd);
    read_reg(`REG_TX_REP, rd, err);
    check_val("tx_rep count", n_rep, rd);
    read_reg(`REG_DROP, rd, err);
    check_val("drop count", n_drop, rd);

    // a request that would match is refused once disabled
    write_reg(`REG_CTRL, 32'h0, 1'b0);
    send_frame(cases[0]);
    expect_silence();
    read_reg(`REG_DROP, rd, err);
    check_val("drop count", n_drop + 1, rd);

    read_reg(8'h20, rd, err);
    check_val("pslverr", 1, err);
    write_reg(`REG_TX_REP, 32'h0, 1'b1);

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

//--- source/arp_responder.sv
`timescale 1ns/1ps
`default_nettype none

module arp_responder (
  input  logic                  clk,
  input  logic                  fsm_rst,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [7:0]            paddr,
  input  logic [31:0]           pwdata,
  output logic [31:0]           prdata,
  output logic                  pready,
  output logic                  pslverr,
  input  arp_pkg::arp_rx_beat_t rx,
  output arp_pkg::arp_tx_beat_t tx,
  input  logic                  tx_ready
);

  arp_pkg::arp_dev_t dev;
  arp_pkg::arp_evt_t evt;
  arp_pkg::arp_hdr_u hdr;
  logic [5:0]        idx;
  logic              hdr_end;
  logic              over_max;
  logic              cnt_clr;
  logic              cnt_inc;
  logic              fsm_cnt_inc;
  logic              bld_cnt_inc;
  logic              shift_en;
  logic              start;
  logic              tx_done;

  // rx bytes and tx bytes never need the counter at the same time
  assign cnt_inc = fsm_cnt_inc | bld_cnt_inc;

  arp_cfg_regs arp_cfg_regs_i (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .evt      (evt),
    .dev      (dev)
  );

  arp_byte_counter arp_byte_counter_i (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .clr      (cnt_clr),
    .inc      (cnt_inc),
    .idx      (idx),
    .hdr_end  (hdr_end),
    .over_max (over_max)
  );

  arp_ctrl_fsm arp_ctrl_fsm_i (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .rx       (rx),
    .hdr      (hdr),
    .dev      (dev),
    .hdr_end  (hdr_end),
    .over_max (over_max),
    .tx_done  (tx_done),
    .cnt_clr  (cnt_clr),
    .cnt_inc  (fsm_cnt_inc),
    .shift_en (shift_en),
    .start    (start),
    .evt      (evt)
  );

  arp_rx_parse arp_rx_parse_i (
    .clk      (clk),
    .rx       (rx),
    .shift_en (shift_en),
    .hdr      (hdr)
  );

  arp_tx_build arp_tx_build_i (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .start    (start),
    .hdr      (hdr),
    .dev      (dev),
    .idx      (idx),
    .tx_ready (tx_ready),
    .cnt_inc  (bld_cnt_inc),
    .tx       (tx),
    .tx_done  (tx_done)
  );

endmodule

`default_nettype wire

//--- source/arp_tx_build.sv
`timescale 1ns/1ps
`default_nettype none

`include "arp_config.svh"

module arp_tx_build (
  input  logic                  clk,
  input  logic                  fsm_rst,
  input  logic                  start,
  input  arp_pkg::arp_hdr_u     hdr,
  input  arp_pkg::arp_dev_t     dev,
  input  logic [5:0]            idx,
  input  logic                  tx_ready,
  output logic                  cnt_inc,
  output arp_pkg::arp_tx_beat_t tx,
  output logic                  tx_done
);

  arp_pkg::arp_hdr_u rep;
  logic              val_q;
  logic              last;
  logic              xfer;
  logic [4:0]        sel;

  assign sel  = 5'(`ARP_HDR_LEN - 1) - idx[4:0]; // idx 0 is the top byte
  assign last = val_q && idx == 6'(`ARP_HDR_LEN - 1);
  assign xfer = val_q && tx_ready;

  assign tx      = '{dat: rep.bytes[sel], val: val_q, last: last};
  assign tx_done = xfer && last;
  assign cnt_inc = xfer && !last; // fsm clears the counter on the final one

  always_ff @(posedge clk) begin
    if (start) begin
      rep.fields.htype <= `ARP_HTYPE_ETH;
      rep.fields.ptype <= `ARP_PTYPE_IPV4;
      rep.fields.hlen  <= `ARP_HLEN_ETH;
      rep.fields.plen  <= `ARP_PLEN_IPV4;
      rep.fields.oper  <= `ARP_OPER_REP;
      rep.fields.sha   <= dev.mac;
      rep.fields.spa   <= dev.ipv4;
      rep.fields.tha   <= hdr.fields.sha; // answer goes back to the asker
      rep.fields.tpa   <= hdr.fields.spa;
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) val_q <= 1'b0;
    else if (start) val_q <= 1'b1;
    else if (tx_done) val_q <= 1'b0;
  end

  // idx only moves on a transfer, so a stalled byte must not change
  a_dat_hold: assert property (@(posedge clk) disable iff (fsm_rst)
    tx.val && !tx_ready |=> $stable(tx.dat));

endmodule

`default_nettype wire

//--- source/arp_rx_parse.sv
`timescale 1ns/1ps
`default_nettype none

`include "arp_config.svh"

module arp_rx_parse (
  input  logic                  clk,
  input  arp_pkg::arp_rx_beat_t rx,
  input  logic                  shift_en,
  output arp_pkg::arp_hdr_u     hdr
);

  // bytes enter at the bottom, so after 28 shifts byte 0 of the frame
  // sits in bytes[27] and the field view lines up with the wire
  always_ff @(posedge clk) begin
    if (shift_en) begin
      hdr.bytes <= {hdr.bytes[`ARP_HDR_LEN-2:0], rx.dat};
    end
  end

endmodule

`default_nettype wire

//--- source/arp_ctrl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "arp_config.svh"

module arp_ctrl_fsm (
  input  logic                  clk,
  input  logic                  fsm_rst,
  input  arp_pkg::arp_rx_beat_t rx,
  input  arp_pkg::arp_hdr_u     hdr,
  input  arp_pkg::arp_dev_t     dev,
  input  logic                  hdr_end,
  input  logic                  over_max,
  input  logic                  tx_done,
  output logic                  cnt_clr,
  output logic                  cnt_inc,
  output logic                  shift_en,
  output logic                  start,
  output arp_pkg::arp_evt_t     evt
);

  arp_pkg::arp_state_t state;
  arp_pkg::arp_state_t state_nxt;
  logic                beat;
  logic                bad;
  logic                bad_nxt;
  logic                in_frame;
  logic                frame_open;
  logic                reply_ok;

  assign beat       = rx.val && rx.is_arp;
  assign frame_open = beat ? !rx.last : in_frame; // a frame still runs after this cycle
  assign reply_ok   = !bad && hdr_end && !over_max && dev.enable
                   && hdr.fields.oper == `ARP_OPER_REQ
                   && hdr.fields.tpa == dev.ipv4;

  always_comb begin
    state_nxt = state;
    bad_nxt   = bad;
    cnt_clr   = 1'b0;
    cnt_inc   = 1'b0;
    shift_en  = 1'b0;
    start     = 1'b0;
    evt       = '0;
    case (state)
      arp_pkg::IDLE, arp_pkg::RECV: begin
        if (beat) begin
          cnt_inc  = 1'b1;
          shift_en = !hdr_end; // padding must not move the header
          if (rx.err || over_max) bad_nxt = 1'b1;
          if (rx.last) state_nxt = arp_pkg::CHECK;
          else if (rx.err || over_max) state_nxt = arp_pkg::DRAIN;
          else state_nxt = arp_pkg::RECV;
        end
      end
      arp_pkg::CHECK: begin
        cnt_clr    = 1'b1; // builder starts from byte 0
        start      = reply_ok;
        evt.rx_req = reply_ok;
        evt.drop   = !reply_ok;
        bad_nxt    = frame_open;
        if (reply_ok) state_nxt = arp_pkg::REPLY;
        else state_nxt = frame_open ? arp_pkg::DRAIN : arp_pkg::IDLE;
      end
      arp_pkg::REPLY: begin
        evt.drop   = beat && rx.last; // frames here are never seen
        evt.tx_rep = tx_done;
        if (tx_done) begin
          cnt_clr   = 1'b1;
          bad_nxt   = frame_open;
          state_nxt = frame_open ? arp_pkg::DRAIN : arp_pkg::IDLE;
        end
      end
      arp_pkg::DRAIN: begin
        if (beat && rx.last) state_nxt = arp_pkg::CHECK;
      end
      default: state_nxt = arp_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state    <= arp_pkg::IDLE;
      bad      <= 1'b0;
      in_frame <= 1'b0;
    end else begin
      state    <= state_nxt;
      bad      <= bad_nxt;
      in_frame <= frame_open;
    end
  end

  // the builder finishes its reply only while the fsm waits in REPLY
  a_done_in_reply: assert property (@(posedge clk) disable iff (fsm_rst)
    tx_done |-> state == arp_pkg::REPLY);

endmodule

`default_nettype wire

//--- source/arp_byte_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "arp_config.svh"

module arp_byte_counter (
  input  logic       clk,
  input  logic       fsm_rst,
  input  logic       clr,
  input  logic       inc,
  output logic [5:0] idx,
  output logic       hdr_end,
  output logic       over_max
);

  localparam logic [5:0] SAT = 6'(`ARP_FRAME_MAX + 1);

  always_ff @(posedge clk) begin
    if (fsm_rst || clr) begin
      idx <= '0;
    end else if (inc && idx != SAT) begin
      idx <= idx + 6'd1; // stops at 47, enough to flag an oversize frame
    end
  end

  assign hdr_end  = idx >= 6'(`ARP_HDR_LEN);
  assign over_max = idx > 6'(`ARP_FRAME_MAX);

  // fsm clears while the builder advances, they must never overlap
  a_clr_inc: assert property (@(posedge clk) disable iff (fsm_rst)
    !(clr && inc));

endmodule

`default_nettype wire

//--- source/arp_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "arp_config.svh"

module arp_cfg_regs (
  input  logic              clk,
  input  logic              fsm_rst,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [7:0]        paddr,
  input  logic [31:0]       pwdata,
  output logic [31:0]       prdata,
  output logic              pready,
  output logic              pslverr,
  input  arp_pkg::arp_evt_t evt,
  output arp_pkg::arp_dev_t dev
);

  logic        setup;
  logic        wr;
  logic        known;
  logic        is_cnt;
  logic [31:0] rd_word;
  logic [31:0] rx_req_cnt;
  logic [31:0] tx_rep_cnt;
  logic [31:0] drop_cnt;

  assign setup  = psel && !penable;
  assign wr     = psel && penable && pwrite;
  assign pready = 1'b1; // no wait states

  always_comb begin
    rd_word = '0;
    known   = 1'b1;
    is_cnt  = 1'b0;
    case (paddr)
      `REG_CTRL:   rd_word = {31'd0, dev.enable};
      `REG_MAC_HI: rd_word = {16'd0, dev.mac[47:32]};
      `REG_MAC_LO: rd_word = dev.mac[31:0];
      `REG_IPV4:   rd_word = dev.ipv4;
      `REG_RX_REQ: begin
        rd_word = rx_req_cnt;
        is_cnt  = 1'b1;
      end
      `REG_TX_REP: begin
        rd_word = tx_rep_cnt;
        is_cnt  = 1'b1;
      end
      `REG_DROP: begin
        rd_word = drop_cnt;
        is_cnt  = 1'b1;
      end
      default: known = 1'b0;
    endcase
  end

  // response is prepared in setup so it is ready for the access phase
  always_ff @(posedge clk) begin
    if (setup) prdata <= rd_word;
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) pslverr <= 1'b0;
    else pslverr <= setup && (!known || (pwrite && is_cnt));
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      dev <= '0;
    end else if (wr) begin
      case (paddr)
        `REG_CTRL:   dev.enable     <= pwdata[0];
        `REG_MAC_HI: dev.mac[47:32] <= pwdata[15:0];
        `REG_MAC_LO: dev.mac[31:0]  <= pwdata;
        `REG_IPV4:   dev.ipv4       <= pwdata;
        default: ; // counters are read only
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      rx_req_cnt <= '0;
      tx_rep_cnt <= '0;
      drop_cnt   <= '0;
    end else begin
      if (evt.rx_req) rx_req_cnt <= rx_req_cnt + 32'd1; // wraps
      if (evt.tx_rep) tx_rep_cnt <= tx_rep_cnt + 32'd1;
      if (evt.drop) drop_cnt <= drop_cnt + 32'd1;
    end
  end

  // master must hold psel/penable for the access phase after setup
  a_err_in_access: assert property (@(posedge clk) disable iff (fsm_rst)
    pslverr |-> psel && penable);

endmodule

`default_nettype wire

//--- source/arp_pkg.sv
`default_nettype none

`include "arp_config.svh"

package arp_pkg;

  typedef struct packed {
    logic [7:0] dat;
    logic       val;
    logic       last;
    logic       err;
    logic       is_arp; // ethertype matched by the MAC
  } arp_rx_beat_t;

  typedef struct packed {
    logic [7:0] dat;
    logic       val;
    logic       last;
  } arp_tx_beat_t;

  // field order is wire order, first byte on top
  typedef struct packed {
    logic [15:0] htype;
    logic [15:0] ptype;
    logic [7:0]  hlen;
    logic [7:0]  plen;
    logic [15:0] oper;
    logic [47:0] sha;
    logic [31:0] spa;
    logic [47:0] tha;
    logic [31:0] tpa;
  } arp_hdr_t;

  typedef union packed {
    arp_hdr_t                        fields;
    logic [`ARP_HDR_LEN-1:0][7:0]    bytes; // bytes[27] is the first on the wire
  } arp_hdr_u;

  typedef struct packed {
    logic [47:0] mac;
    logic [31:0] ipv4;
    logic        enable;
  } arp_dev_t;

  typedef struct packed {
    logic rx_req;
    logic tx_rep;
    logic drop;
  } arp_evt_t;

  typedef enum logic [2:0] {
    IDLE,
    RECV,
    CHECK,
    REPLY,
    DRAIN
  } arp_state_t;

endpackage

`default_nettype wire

//--- source/arp_config.svh
`ifndef ARP_CONFIG_SVH
`define ARP_CONFIG_SVH

`define ARP_HDR_LEN     28
`define ARP_FRAME_MAX   46 // minimum ethernet payload, padding included

`define ARP_HTYPE_ETH   16'd1
`define ARP_PTYPE_IPV4  16'h0800
`define ARP_HLEN_ETH    8'd6
`define ARP_PLEN_IPV4   8'd4
`define ARP_OPER_REQ    16'd1
`define ARP_OPER_REP    16'd2

`define REG_CTRL        8'h00
`define REG_MAC_HI      8'h04
`define REG_MAC_LO      8'h08
`define REG_IPV4        8'h0C
`define REG_RX_REQ      8'h10
`define REG_TX_REP      8'h14
`define REG_DROP        8'h18

`endif
